//--- include/ant_cfg.svh
`ifndef ANT_CFG_SVH
`define ANT_CFG_SVH

// Coordinate and identifier widths
`define ANT_X_WIDTH         8
`define ANT_Y_WIDTH         7
`define ANT_ID_WIDTH        8

// Datapath word widths
`define MEM_ADDR_WIDTH      10
`define RESULT_WIDTH        16
`define INSTRUCTION_WIDTH   32

// Opcodes in the low bits of every instruction
`define OPCODE_WIDTH        3
`define OPCODE_MEMREAD      `OPCODE_WIDTH'd1
`define OPCODE_MEMWRITE     `OPCODE_WIDTH'd2
`define OPCODE_DRAW         `OPCODE_WIDTH'd3

// Ant record: the id followed by a two-bit field select
`define ANT_FIELD_WIDTH     2
`define FIELD_ANT_X         `ANT_FIELD_WIDTH'd0
`define FIELD_ANT_Y         `ANT_FIELD_WIDTH'd1
`define ANT_RECORD_ADDR(ant_id, field) {ant_id, field}

// Screen and movement margins
`define SCREEN_WIDTH        160
`define SCREEN_HEIGHT       120
`define BLOCK_WIDTH         4
`define BLOCK_HEIGHT        4

// Drawn ant block
`define ANT_WIDTH           4
`define ANT_HEIGHT          4
`define COLOUR_WIDTH        3
`define COLOUR_ANT          3'b010

`endif

//--- hw/ant_pkg.sv
`include "ant_cfg.svh"

package ant_pkg;

    typedef logic [`INSTRUCTION_WIDTH-1:0] instr_word_t;

    // Memory read and write, opcode in the lowest bits
    typedef struct packed {
        logic [`INSTRUCTION_WIDTH-`RESULT_WIDTH-`MEM_ADDR_WIDTH-`OPCODE_WIDTH-1:0] pad;
        logic [`RESULT_WIDTH-1:0]   data;
        logic [`MEM_ADDR_WIDTH-1:0] addr;
        logic [`OPCODE_WIDTH-1:0]   opcode;
    } mem_instr_t;

    // One pixel plot
    typedef struct packed {
        logic [`INSTRUCTION_WIDTH-`COLOUR_WIDTH-`ANT_Y_WIDTH-`ANT_X_WIDTH-`OPCODE_WIDTH-2:0] pad;
        logic                       plot;
        logic [`COLOUR_WIDTH-1:0]   colour;
        logic [`ANT_Y_WIDTH-1:0]    y;
        logic [`ANT_X_WIDTH-1:0]    x;
        logic [`OPCODE_WIDTH-1:0]   opcode;
    } draw_instr_t;

    typedef struct packed {
        logic [`ANT_X_WIDTH-1:0] x;
        logic [`ANT_Y_WIDTH-1:0] y;
    } ant_pos_t;

    // Toward the datapath
    typedef struct packed {
        logic        start;
        instr_word_t instr;
    } dp_port_t;

    // Back from the datapath, result valid with finished
    typedef struct packed {
        logic                     finished;
        logic [`RESULT_WIDTH-1:0] result;
    } dp_reply_t;

endpackage

//--- hw/dp_request.sv
`include "ant_cfg.svh"

module dp_request #(
    parameter type payload_t = ant_pkg::instr_word_t
) (
    input  logic                     clock,
    input  logic                     resetn,
    input  logic                     go,
    input  payload_t                 payload,
    output ant_pkg::dp_port_t        dp,
    input  ant_pkg::dp_reply_t       reply,
    output logic                     done,
    output logic [`RESULT_WIDTH-1:0] result
);

    typedef enum logic [1:0] {
        S_IDLE,
        S_STROBE,
        S_WAIT
    } state_t;

    state_t   state;
    logic     strobe_last;
    payload_t payload_q;

    always_ff @(posedge clock) begin
        if (!resetn) begin
            state       <= S_IDLE;
            strobe_last <= 1'b0;
            done        <= 1'b0;
        end else begin
            done <= 1'b0;
            case (state)
                S_IDLE: begin
                    if (go) begin
                        state       <= S_STROBE;
                        strobe_last <= 1'b0;
                    end
                end
                S_STROBE: begin
                    // Start stays up for two cycles
                    strobe_last <= 1'b1;
                    if (strobe_last) begin
                        state <= S_WAIT;
                    end
                end
                S_WAIT: begin
                    if (reply.finished) begin
                        state <= S_IDLE;
                        done  <= 1'b1;
                    end
                end
                default: begin
                    state <= S_IDLE;
                end
            endcase
        end
    end

    always_ff @(posedge clock) begin
        if (go && state == S_IDLE) begin
            payload_q <= payload;
        end
        if (state == S_WAIT && reply.finished) begin
            result <= reply.result;
        end
    end

    // Instruction held from the strobe until the reply
    assign dp.start = (state == S_STROBE);
    assign dp.instr = ant_pkg::instr_word_t'(payload_q);

    // Clients only issue a new request after the previous done
    assert property (@(posedge clock) disable iff (!resetn) go |-> state == S_IDLE);

    // Datapath answers only once the strobe has dropped
    assert property (@(posedge clock) disable iff (!resetn)
        reply.finished |-> state != S_STROBE);

endmodule

//--- hw/ant_update.sv
`include "ant_cfg.svh"

module ant_update (
    input  logic                     clock,
    input  logic                     resetn,
    input  logic                     go,
    input  logic [`ANT_ID_WIDTH-1:0] id,
    output ant_pkg::dp_port_t        dp,
    input  ant_pkg::dp_reply_t       reply,
    output logic                     done,
    output ant_pkg::ant_pos_t        pos
);

    typedef enum logic [2:0] {
        S_IDLE,
        S_READ_X,
        S_READ_Y,
        S_MOVE,
        S_WRITE_X,
        S_WRITE_Y
    } state_t;

    state_t                   state;
    logic                     req_go;
    logic                     req_done;
    logic [`RESULT_WIDTH-1:0] req_result;
    ant_pkg::mem_instr_t      req_instr;

    // Heading shared by all ants, two's complement +1 or -1 per axis
    logic [`ANT_X_WIDTH-1:0]  heading_x;
    logic [`ANT_Y_WIDTH-1:0]  heading_y;
    ant_pkg::ant_pos_t        next_pos;
    logic                     flip_x;
    logic                     flip_y;

    always_comb begin
        next_pos.x = pos.x + heading_x;
        next_pos.y = pos.y + heading_y;
        // Bounce when the moved block touches an edge in its direction of travel
        if (heading_x == `ANT_X_WIDTH'd1) begin
            flip_x = (next_pos.x >= `ANT_X_WIDTH'(`SCREEN_WIDTH - `BLOCK_WIDTH));
        end else begin
            flip_x = (next_pos.x == '0);
        end
        if (heading_y == `ANT_Y_WIDTH'd1) begin
            flip_y = (next_pos.y >= `ANT_Y_WIDTH'(`SCREEN_HEIGHT - `BLOCK_HEIGHT));
        end else begin
            flip_y = (next_pos.y == '0);
        end
    end

    always_comb begin
        req_instr        = '0;
        req_instr.opcode = `OPCODE_MEMREAD;
        req_instr.addr   = `ANT_RECORD_ADDR(id, `FIELD_ANT_X);
        case (state)
            S_READ_Y: begin
                req_instr.addr = `ANT_RECORD_ADDR(id, `FIELD_ANT_Y);
            end
            S_WRITE_X: begin
                req_instr.opcode = `OPCODE_MEMWRITE;
                req_instr.data   = `RESULT_WIDTH'(pos.x);
            end
            S_WRITE_Y: begin
                req_instr.opcode = `OPCODE_MEMWRITE;
                req_instr.addr   = `ANT_RECORD_ADDR(id, `FIELD_ANT_Y);
                req_instr.data   = `RESULT_WIDTH'(pos.y);
            end
            default: begin
            end
        endcase
    end

    always_ff @(posedge clock) begin
        if (!resetn) begin
            state     <= S_IDLE;
            req_go    <= 1'b0;
            heading_x <= `ANT_X_WIDTH'd1;
            heading_y <= `ANT_Y_WIDTH'd1;
        end else begin
            req_go <= 1'b0;
            case (state)
                S_IDLE: begin
                    if (go) begin
                        state  <= S_READ_X;
                        req_go <= 1'b1;
                    end
                end
                S_READ_X: begin
                    if (req_done) begin
                        state  <= S_READ_Y;
                        req_go <= 1'b1;
                    end
                end
                S_READ_Y: begin
                    if (req_done) begin
                        state <= S_MOVE;
                    end
                end
                S_MOVE: begin
                    // New heading applies from the next step
                    state  <= S_WRITE_X;
                    req_go <= 1'b1;
                    if (flip_x) begin
                        heading_x <= -heading_x;
                    end
                    if (flip_y) begin
                        heading_y <= -heading_y;
                    end
                end
                S_WRITE_X: begin
                    if (req_done) begin
                        state  <= S_WRITE_Y;
                        req_go <= 1'b1;
                    end
                end
                S_WRITE_Y: begin
                    if (req_done) begin
                        state <= S_IDLE;
                    end
                end
                default: begin
                    state <= S_IDLE;
                end
            endcase
        end
    end

    always_ff @(posedge clock) begin
        if (state == S_READ_X && req_done) begin
            pos.x <= req_result[`ANT_X_WIDTH-1:0];
        end
        if (state == S_READ_Y && req_done) begin
            pos.y <= req_result[`ANT_Y_WIDTH-1:0];
        end
        if (state == S_MOVE) begin
            pos <= next_pos;
        end
    end

    assign done = (state == S_WRITE_Y) && req_done;

    dp_request #(
        .payload_t (ant_pkg::mem_instr_t)
    ) dp_request_inst (
        .clock   (clock),
        .resetn  (resetn),
        .go      (req_go),
        .payload (req_instr),
        .dp      (dp),
        .reply   (reply),
        .done    (req_done),
        .result  (req_result)
    );

    // Positions written back stay on screen across steps
    assert property (@(posedge clock) disable iff (!resetn)
        req_go && state == S_WRITE_X |-> pos.x < `SCREEN_WIDTH);
    assert property (@(posedge clock) disable iff (!resetn)
        req_go && state == S_WRITE_Y |-> pos.y < `SCREEN_HEIGHT);

endmodule

//--- hw/ant_draw.sv
`include "ant_cfg.svh"

module ant_draw (
    input  logic               clock,
    input  logic               resetn,
    input  logic               go,
    input  ant_pkg::ant_pos_t  origin,
    output ant_pkg::dp_port_t  dp,
    input  ant_pkg::dp_reply_t reply,
    output logic               done
);

    typedef enum logic {
        S_IDLE,
        S_PLOT
    } state_t;

    state_t                          state;
    logic                            req_go;
    logic                            req_done;
    ant_pkg::draw_instr_t            req_instr;
    ant_pkg::ant_pos_t               base;
    logic [$clog2(`ANT_WIDTH)-1:0]   col;
    logic [$clog2(`ANT_HEIGHT)-1:0]  row;
    logic                            last_col;
    logic                            last_row;

    assign last_col = (col == ($clog2(`ANT_WIDTH))'(`ANT_WIDTH - 1));
    assign last_row = (row == ($clog2(`ANT_HEIGHT))'(`ANT_HEIGHT - 1));

    always_comb begin
        req_instr        = '0;
        req_instr.plot   = 1'b1;
        req_instr.colour = `COLOUR_ANT;
        req_instr.x      = base.x + `ANT_X_WIDTH'(col);
        req_instr.y      = base.y + `ANT_Y_WIDTH'(row);
        req_instr.opcode = `OPCODE_DRAW;
    end

    always_ff @(posedge clock) begin
        if (!resetn) begin
            state  <= S_IDLE;
            req_go <= 1'b0;
            col    <= '0;
            row    <= '0;
        end else begin
            req_go <= 1'b0;
            case (state)
                S_IDLE: begin
                    if (go) begin
                        state  <= S_PLOT;
                        req_go <= 1'b1;
                        col    <= '0;
                        row    <= '0;
                    end
                end
                S_PLOT: begin
                    // Column steps fastest, then row
                    if (req_done) begin
                        if (last_col) begin
                            col <= '0;
                            row <= last_row ? '0 : row + 1'b1;
                        end else begin
                            col <= col + 1'b1;
                        end
                        if (last_col && last_row) begin
                            state <= S_IDLE;
                        end else begin
                            req_go <= 1'b1;
                        end
                    end
                end
                default: begin
                    state <= S_IDLE;
                end
            endcase
        end
    end

    // Block is drawn one pixel up and left of the ant position
    always_ff @(posedge clock) begin
        if (go && state == S_IDLE) begin
            base.x <= origin.x - 1'b1;
            base.y <= origin.y - 1'b1;
        end
    end

    assign done = (state == S_PLOT) && req_done && last_col && last_row;

    dp_request #(
        .payload_t (ant_pkg::draw_instr_t)
    ) dp_request_inst (
        .clock   (clock),
        .resetn  (resetn),
        .go      (req_go),
        .payload (req_instr),
        .dp      (dp),
        .reply   (reply),
        .done    (req_done),
        .result  ()
    );

endmodule

//--- hw/ant_step_sequencer.sv
`include "ant_cfg.svh"

module ant_step_sequencer (
    input  logic                     clock,
    input  logic                     resetn,
    input  logic                     start,
    input  logic [`ANT_ID_WIDTH-1:0] id,
    output logic                     finished,
    output logic                     update_go,
    output logic                     draw_go,
    input  logic                     update_done,
    input  logic                     draw_done,
    input  ant_pkg::dp_port_t        update_dp,
    input  ant_pkg::dp_port_t        draw_dp,
    output ant_pkg::dp_port_t        dp_out,
    input  ant_pkg::dp_reply_t       dp_in,
    output ant_pkg::dp_reply_t       update_reply,
    output ant_pkg::dp_reply_t       draw_reply,
    output logic [`ANT_ID_WIDTH-1:0] ant_id
);

    typedef enum logic [1:0] {
        S_IDLE,
        S_UPDATE,
        S_DRAW,
        S_FINISH
    } state_t;

    state_t state;

    always_ff @(posedge clock) begin
        if (!resetn) begin
            state     <= S_IDLE;
            update_go <= 1'b0;
            draw_go   <= 1'b0;
        end else begin
            update_go <= 1'b0;
            draw_go   <= 1'b0;
            case (state)
                S_IDLE: begin
                    if (start) begin
                        state     <= S_UPDATE;
                        update_go <= 1'b1;
                    end
                end
                S_UPDATE: begin
                    if (update_done) begin
                        state   <= S_DRAW;
                        draw_go <= 1'b1;
                    end
                end
                S_DRAW: begin
                    if (draw_done) begin
                        state <= S_FINISH;
                    end
                end
                default: begin
                    state <= S_IDLE;
                end
            endcase
        end
    end

    always_ff @(posedge clock) begin
        if (state == S_IDLE && start) begin
            ant_id <= id;
        end
    end

    assign finished = (state == S_IDLE);

    // Only the active client reaches the datapath and sees its finished
    always_comb begin
        dp_out                = '0;
        update_reply          = dp_in;
        update_reply.finished = 1'b0;
        draw_reply            = dp_in;
        draw_reply.finished   = 1'b0;
        case (state)
            S_UPDATE: begin
                dp_out                = update_dp;
                update_reply.finished = dp_in.finished;
            end
            S_DRAW: begin
                dp_out              = draw_dp;
                draw_reply.finished = dp_in.finished;
            end
            default: begin
            end
        endcase
    end

endmodule

//--- hw/ant_engine.sv
`include "ant_cfg.svh"

module ant_engine (
    input  logic                     clock,
    input  logic                     resetn,
    input  logic                     start,
    input  logic [`ANT_ID_WIDTH-1:0] id,
    output logic                     finished,
    output ant_pkg::dp_port_t        dp_out,
    input  ant_pkg::dp_reply_t       dp_in
);

    logic                     update_go;
    logic                     draw_go;
    logic                     update_done;
    logic                     draw_done;
    logic [`ANT_ID_WIDTH-1:0] ant_id;
    ant_pkg::dp_port_t        update_dp;
    ant_pkg::dp_port_t        draw_dp;
    ant_pkg::dp_reply_t       update_reply;
    ant_pkg::dp_reply_t       draw_reply;
    ant_pkg::ant_pos_t        new_pos;

    ant_step_sequencer ant_step_sequencer_inst (
        .clock        (clock),
        .resetn       (resetn),
        .start        (start),
        .id           (id),
        .finished     (finished),
        .update_go    (update_go),
        .draw_go      (draw_go),
        .update_done  (update_done),
        .draw_done    (draw_done),
        .update_dp    (update_dp),
        .draw_dp      (draw_dp),
        .dp_out       (dp_out),
        .dp_in        (dp_in),
        .update_reply (update_reply),
        .draw_reply   (draw_reply),
        .ant_id       (ant_id)
    );

    ant_update ant_update_inst (
        .clock  (clock),
        .resetn (resetn),
        .go     (update_go),
        .id     (ant_id),
        .dp     (update_dp),
        .reply  (update_reply),
        .done   (update_done),
        .pos    (new_pos)
    );

    // Draw at the position just written back
    ant_draw ant_draw_inst (
        .clock  (clock),
        .resetn (resetn),
        .go     (draw_go),
        .origin (new_pos),
        .dp     (draw_dp),
        .reply  (draw_reply),
        .done   (draw_done)
    );

endmodule

//--- test/dp_model.sv
`include "ant_cfg.svh"

module dp_model (
    input  logic               clock,
    input  logic               resetn,
    input  int                 max_latency,
    input  ant_pkg::dp_port_t  dp,
    output ant_pkg::dp_reply_t reply
);

    logic [`RESULT_WIDTH-1:0] mem [0:(1 << `MEM_ADDR_WIDTH)-1];
    ant_pkg::mem_instr_t      mem_log[$];
    ant_pkg::draw_instr_t     draw_log[$];
    ant_pkg::instr_word_t     instr_q;
    ant_pkg::mem_instr_t      op;
    logic                     start_q;
    int                       count;

    // Background contents that differ at every address
    initial begin
        for (int a = 0; a < (1 << `MEM_ADDR_WIDTH); a++) begin
            mem[a] = 16'(a * 16'h9e37) ^ 16'h5a00;
        end
    end

    always @(posedge clock) begin
        if (!resetn) begin
            start_q <= 1'b0;
            count   <= 0;
            reply   <= '0;
        end else begin
            reply.finished <= 1'b0;
            start_q        <= dp.start;
            if (dp.start && !start_q) begin
                instr_q <= dp.instr;
            end
            // Latency counts from the first cycle after the strobe
            if (start_q && !dp.start) begin
                count <= int'($urandom_range(max_latency, 1));
            end else if (count > 0) begin
                count <= count - 1;
            end
            if (count == 1) begin
                op = ant_pkg::mem_instr_t'(instr_q);
                if (op.opcode == `OPCODE_MEMREAD) begin
                    reply.result <= mem[op.addr];
                    mem_log.push_back(op);
                end else if (op.opcode == `OPCODE_MEMWRITE) begin
                    mem[op.addr] = op.data;
                    mem_log.push_back(op);
                end else if (op.opcode == `OPCODE_DRAW) begin
                    draw_log.push_back(ant_pkg::draw_instr_t'(instr_q));
                end
                reply.finished <= 1'b1;
            end
        end
    end

endmodule

//--- test/ant_engine_tb.sv
`include "ant_cfg.svh"

module ant_engine_tb;

    logic                     clock;
    logic                     resetn;
    logic                     start;
    logic [`ANT_ID_WIDTH-1:0] id;
    logic                     finished;
    ant_pkg::dp_port_t        dp_out;
    ant_pkg::dp_reply_t       dp_in;
    int                       max_latency;
    logic                     started;
    logic                     start_seen;
    logic                     waiting;
    int                       errors;
    int                       tests_passed;
    int                       tests_failed;
    // Reference model state
    int                       ref_x [0:255];
    int                       ref_y [0:255];
    int                       head_x;
    int                       head_y;

    ant_engine ant_engine_inst (
        .clock    (clock),
        .resetn   (resetn),
        .start    (start),
        .id       (id),
        .finished (finished),
        .dp_out   (dp_out),
        .dp_in    (dp_in)
    );

    dp_model dp_model_inst (
        .clock       (clock),
        .resetn      (resetn),
        .max_latency (max_latency),
        .dp          (dp_out),
        .reply       (dp_in)
    );

    initial begin
        clock = 1'b0;
        forever #2 clock = ~clock;
    end

    // Outstanding request between the strobe and its finished pulse
    always @(posedge clock) begin
        if (!resetn) begin
            start_seen <= 1'b0;
            waiting    <= 1'b0;
        end else begin
            start_seen <= dp_out.start;
            waiting    <= (waiting && !dp_in.finished) || (start_seen && !dp_out.start);
        end
    end

    assert property (@(posedge clock) disable iff (!resetn) !started |-> finished && !dp_out.start)
    else begin
        errors++;
        $display("finished low or datapath start high before the first step");
    end
    assert property (@(posedge clock) disable iff (!resetn)
        $rose(dp_out.start) |=> dp_out.start ##1 !dp_out.start)
    else begin
        errors++;
        $display("datapath start was not held for exactly two cycles");
    end
    assert property (@(posedge clock) disable iff (!resetn)
        dp_out.start && $past(dp_out.start) |-> $stable(dp_out.instr))
    else begin
        errors++;
        $display("instruction changed during the start strobe");
    end
    assert property (@(posedge clock) disable iff (!resetn)
        waiting |-> !dp_out.start && $stable(dp_out.instr))
    else begin
        errors++;
        $display("start raised or instruction changed while waiting for finished");
    end
    assert property (@(posedge clock) disable iff (!resetn)
        $rose(finished) |-> !waiting && !dp_out.start)
    else begin
        errors++;
        $display("finished rose while a datapath request was still open");
    end

    task automatic abort_run(input string reason);
        $display("Timeout: %s", reason);
        $display("Result: FAILED");
        $finish;
    endtask

    task automatic expect_equal(input string name, input int got, input int exp);
        assert (got == exp)
        else begin
            errors++;
            $display("** Error: %s got %h expected %h", name, got, exp);
        end
    endtask

    task automatic wait_finished_level(input logic level);
        int cycles;
        cycles = 0;
        while (finished !== level) begin
            @(posedge clock);
            cycles++;
            if (cycles > 20000) begin
                abort_run("finished did not reach the expected level");
            end
        end
    endtask

    task automatic place_ant(input int ant, input int x, input int y);
        ref_x[ant] = x;
        ref_y[ant] = y;
        dp_model_inst.mem[ant * 4 + 0] = 16'(x);
        dp_model_inst.mem[ant * 4 + 1] = 16'(y);
    endtask

    // One step for one ant, checked against the reference model
    task automatic run_step(input int ant);
        int nx;
        int ny;
        ant_pkg::mem_instr_t  m;
        ant_pkg::draw_instr_t d;
        nx = (ref_x[ant] + head_x) & 8'hff;
        ny = (ref_y[ant] + head_y) & 7'h7f;
        if ((head_x == 1 && nx >= `SCREEN_WIDTH - `BLOCK_WIDTH) || (head_x == -1 && nx == 0)) begin
            head_x = -head_x;
        end
        if ((head_y == 1 && ny >= `SCREEN_HEIGHT - `BLOCK_HEIGHT) || (head_y == -1 && ny == 0)) begin
            head_y = -head_y;
        end
        ref_x[ant] = nx;
        ref_y[ant] = ny;
        dp_model_inst.mem_log.delete();
        dp_model_inst.draw_log.delete();
        @(posedge clock);
        started <= 1'b1;
        start   <= 1'b1;
        id      <= 8'(ant);
        @(posedge clock);
        start <= 1'b0;
        wait_finished_level(1'b0);
        wait_finished_level(1'b1);
        expect_equal("mem x", int'(dp_model_inst.mem[ant * 4 + 0]), nx);
        expect_equal("mem y", int'(dp_model_inst.mem[ant * 4 + 1]), ny);
        expect_equal("memory op count", dp_model_inst.mem_log.size(), 4);
        for (int i = 0; i < dp_model_inst.mem_log.size() && i < 4; i++) begin
            m = dp_model_inst.mem_log[i];
            expect_equal("mem opcode", int'(m.opcode), i < 2 ? 1 : 2);
            expect_equal("mem addr", int'(m.addr), ant * 4 + (i % 2));
            if (i >= 2) begin
                expect_equal("mem data", int'(m.data), i == 2 ? nx : ny);
            end
        end
        expect_equal("draw count", dp_model_inst.draw_log.size(), 16);
        for (int i = 0; i < dp_model_inst.draw_log.size() && i < 16; i++) begin
            d = dp_model_inst.draw_log[i];
            expect_equal("draw plot", int'(d.plot), 1);
            expect_equal("draw colour", int'(d.colour), int'(`COLOUR_ANT));
            expect_equal("draw x", int'(d.x), (nx - 1 + i % 4) & 8'hff);
            expect_equal("draw y", int'(d.y), (ny - 1 + i / 4) & 7'h7f);
        end
    endtask

    task automatic report_test(input string name, input int errors_before);
        if (errors == errors_before) begin
            tests_passed++;
            $display("test %s: ok", name);
        end else begin
            tests_failed++;
            $display("test %s: failed with %0d errors", name, errors - errors_before);
        end
    endtask

    initial begin
        int e;
        void'($urandom(32'h6ac3));
        resetn       = 1'b0;
        start        = 1'b0;
        id           = '0;
        started      = 1'b0;
        max_latency  = 6;
        errors       = 0;
        tests_passed = 0;
        tests_failed = 0;
        head_x       = 1;
        head_y       = 1;
        repeat (16) @(posedge clock);
        resetn <= 1'b1;

        e = errors;
        repeat (8) @(posedge clock);
        expect_equal("finished", int'(finished), 1);
        expect_equal("dp_out.start", int'(dp_out.start), 0);
        report_test("reset", e);

        e = errors;
        place_ant(5, 20, 30);
        run_step(5);
        report_test("single step", e);

        e = errors;
        place_ant(7, 155, 50);
        run_step(7);
        expect_equal("ant 7 mem x", int'(dp_model_inst.mem[7 * 4 + 0]), 156);
        run_step(7);
        expect_equal("ant 7 mem x", int'(dp_model_inst.mem[7 * 4 + 0]), 155);
        place_ant(9, 80, 115);
        run_step(9);
        expect_equal("ant 9 mem y", int'(dp_model_inst.mem[9 * 4 + 1]), 116);
        run_step(9);
        expect_equal("ant 9 mem y", int'(dp_model_inst.mem[9 * 4 + 1]), 115);
        report_test("bounce", e);

        e = errors;
        max_latency = 40;
        for (int a = 1; a <= 4; a++) begin
            place_ant(a, int'($urandom_range(140, 10)), int'($urandom_range(100, 10)));
        end
        for (int s = 0; s < 8; s++) begin
            run_step(s % 4 + 1);
        end
        report_test("back-pressure", e);

        $display("tests passed %0d, failed %0d, errors %0d", tests_passed, tests_failed, errors);
        if (errors == 0 && tests_failed == 0) begin
            $display("Result: PASSED");
        end else begin
            $display("Result: FAILED");
        end
        $finish;
    end

endmodule

//--- all.f
+incdir+include
hw/ant_pkg.sv
hw/dp_request.sv
hw/ant_update.sv
hw/ant_draw.sv
hw/ant_step_sequencer.sv
hw/ant_engine.sv
test/dp_model.sv
test/ant_engine_tb.sv

//--- Makefile
VERILATOR ?= verilator
FLAGS     ?= --binary --assert --timing -j 0
TOP       ?= ant_engine_tb
FILELIST  ?= all.f
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log

BIN     := $(OBJ_DIR)/V$(TOP)
SOURCES := $(wildcard hw/*.sv) $(wildcard test/*.sv) $(wildcard include/*.svh)

.PHONY: all run clean

all: $(BIN)

$(BIN): $(SOURCES) $(FILELIST)
	$(VERILATOR) $(FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)

run: $(BIN)
	./$(BIN) | tee $(LOG)
	@if grep -q "Result: FAILED" $(LOG); then exit 1; fi
	@grep -q "Result: PASSED" $(LOG)

clean:
	rm -rf $(OBJ_DIR) $(LOG)
